//--- hdl/emu_macros.svh
`ifndef EMU_MACROS_SVH
`define EMU_MACROS_SVH

// Register byte addresses
`define EMU_STAT            12'h000
`define EMU_CYCLE_LO        12'h004
`define EMU_CYCLE_HI        12'h008
`define EMU_STEP            12'h00C
`define EMU_CKPT_SIZE       12'h010
`define EMU_TRIG_STAT       12'h014
`define EMU_TRIG_EN         12'h018
`define EMU_SCAN_CTRL       12'h01C

// STAT bit positions
`define STAT_PAUSE_BIT      0
`define STAT_DUT_RST_BIT    1
`define STAT_SCAN_BUSY_BIT  2
`define STAT_STEP_TRIG_BIT  31

// SCAN_CTRL bit positions, direction 1 means scan-in
`define SCAN_START_BIT      0
`define SCAN_DIR_BIT        1

`define RESP_SLVERR         2'd2

`define DEF_CHAIN_FF_WORDS  4
`define DEF_CHAIN_MEM_WORDS 3

`endif

//--- hdl/emu_pkg.sv
package emu_pkg;

    // Register bus
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // Target cycle count
    typedef logic [63:0] cycle_t;

    // One bit per trigger input
    typedef logic [31:0] trig_t;

    // One word of the flip-flop or memory chain
    typedef logic [63:0] scan_word_t;

    // Scan sequencer phases
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        FF   = 2'd1,
        RAM  = 2'd2
    } scan_state_e;

endpackage

//--- hdl/emu_csr_if.sv
interface emu_csr_if;

    // Decoded write, one cycle per accepted full-strobe write
    logic                wr_en;
    emu_pkg::csr_addr_t  wr_addr;
    emu_pkg::csr_data_t  wr_data;

    // Read address and per-block return data, zero when not addressed
    emu_pkg::csr_addr_t  rd_addr;
    emu_pkg::csr_data_t  run_rdata;
    emu_pkg::csr_data_t  scan_rdata;

    modport ctrl (
        output wr_en, wr_addr, wr_data, rd_addr,
        input  run_rdata, scan_rdata
    );

    modport run (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output run_rdata
    );

    modport scan (
        input  wr_en, wr_addr, wr_data, rd_addr,
        output scan_rdata
    );

endinterface

//--- hdl/emu_csr_ctrl.sv
`include "emu_macros.svh"

module emu_csr_ctrl #(
    parameter int chain_ff_words  = `DEF_CHAIN_FF_WORDS,
    parameter int chain_mem_words = `DEF_CHAIN_MEM_WORDS
) (
    input  logic               clk,
    input  logic               rst,

    input  emu_pkg::csr_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  emu_pkg::csr_data_t wdata,
    input  logic [3:0]         wstrb,
    input  logic               wvalid,
    output logic               wready,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready,

    input  emu_pkg::csr_addr_t araddr,
    input  logic               arvalid,
    output logic               arready,
    output emu_pkg::csr_data_t rdata,
    output logic [1:0]         rresp,
    output logic               rvalid,
    input  logic               rready,

    emu_csr_if.ctrl            csr
);

    // Checkpoint size in bytes, 8 per chain word
    localparam emu_pkg::csr_data_t ckpt_size =
        emu_pkg::csr_data_t'(8 * (chain_ff_words + chain_mem_words));

    // Write channel
    emu_pkg::csr_addr_t wr_addr_q;
    emu_pkg::csr_data_t wr_data_q;
    logic               wr_strb_ok;
    logic               aw_held;
    logic               w_held;
    logic               b_held;
    logic               b_err;
    logic               wr_en_q;
    logic               wr_both;

    // Read channel
    emu_pkg::csr_addr_t rd_addr_q;
    emu_pkg::csr_data_t rdata_q;
    emu_pkg::csr_data_t ckpt_rdata;
    logic               ar_held;
    logic               r_held;
    logic               rd_pending;

    assign wr_both    = aw_held && w_held;
    assign rd_pending = ar_held && !r_held;

    // Checkpoint size register
    assign ckpt_rdata = (rd_addr_q == `EMU_CKPT_SIZE) ? ckpt_size : '0;

    // Payload capture
    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr_addr_q <= awaddr;
        end
        if (wvalid && wready) begin
            wr_data_q  <= wdata;
            wr_strb_ok <= &wstrb;
        end
        if (arvalid && arready) begin
            rd_addr_q <= araddr;
        end
        if (rd_pending) begin
            rdata_q <= csr.run_rdata | csr.scan_rdata | ckpt_rdata;
        end
    end

    // Channel handshake state
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            b_held  <= 1'b0;
            b_err   <= 1'b0;
            wr_en_q <= 1'b0;
            ar_held <= 1'b0;
            r_held  <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
            end
            // Address and data both present, apply and respond
            if (wr_both) begin
                aw_held <= 1'b0;
                w_held  <= 1'b0;
                b_held  <= 1'b1;
                b_err   <= !wr_strb_ok;
                wr_en_q <= wr_strb_ok;
            end
            if (bvalid && bready) begin
                b_held <= 1'b0;
            end

            if (arvalid && arready) begin
                ar_held <= 1'b1;
            end
            if (rd_pending) begin
                r_held <= 1'b1;
            end
            if (rvalid && rready) begin
                ar_held <= 1'b0;
                r_held  <= 1'b0;
            end
        end
    end

    assign awready = !aw_held && !b_held;
    assign wready  = !w_held;
    assign bvalid  = b_held;
    assign bresp   = b_err ? `RESP_SLVERR : 2'b00;

    assign arready = !ar_held;
    assign rvalid  = r_held;
    assign rdata   = rdata_q;
    assign rresp   = 2'b00;

    assign csr.wr_en   = wr_en_q;
    assign csr.wr_addr = wr_addr_q;
    assign csr.wr_data = wr_data_q;
    assign csr.rd_addr = rd_addr_q;

endmodule

//--- hdl/emu_run_ctrl.sv
`include "emu_macros.svh"

module emu_run_ctrl (
    input  logic           clk,
    input  logic           rst,
    emu_csr_if.run         csr,
    input  logic           stall,
    input  emu_pkg::trig_t trig,
    input  logic           scan_busy,
    output logic           target_fire,
    output logic           dut_clk_en,
    output logic           dut_rst
);

    logic               pause;
    logic               step_trig;
    emu_pkg::cycle_t    cycle;
    emu_pkg::csr_data_t step;
    emu_pkg::csr_data_t step_next;
    emu_pkg::trig_t     trig_en;
    emu_pkg::trig_t     trig_stat;
    emu_pkg::csr_data_t stat;
    logic               step_hit;
    logic               trig_hit;

    // No target clock while the chains are being scanned
    assign target_fire = !pause && !stall;
    assign dut_clk_en  = target_fire && !scan_busy;

    always_comb begin
        if (dut_clk_en && step != '0) begin
            step_next = step - 1'b1;
        end else begin
            step_next = step;
        end
    end

    // Step count expires on this enabled cycle
    assign step_hit = (step != '0) && (step_next == '0);
    assign trig_hit = |(trig & trig_en);

    always_ff @(posedge clk) begin
        if (rst) begin
            pause     <= 1'b1;
            dut_rst   <= 1'b1;
            step_trig <= 1'b0;
        end else begin
            if (csr.wr_en && csr.wr_addr == `EMU_STAT) begin
                pause   <= csr.wr_data[`STAT_PAUSE_BIT];
                dut_rst <= csr.wr_data[`STAT_DUT_RST_BIT];
            end
            // A trigger wins over a STAT write in the same cycle
            if (step_hit || trig_hit) begin
                pause     <= 1'b1;
                step_trig <= step_hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (dut_clk_en) begin
            cycle <= cycle + 1'b1;
        end else begin
            if (csr.wr_en && csr.wr_addr == `EMU_CYCLE_LO) begin
                cycle[31:0] <= csr.wr_data;
            end
            if (csr.wr_en && csr.wr_addr == `EMU_CYCLE_HI) begin
                cycle[63:32] <= csr.wr_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step      <= '0;
            trig_en   <= '0;
            trig_stat <= '0;
        end else begin
            if (csr.wr_en && csr.wr_addr == `EMU_STEP) begin
                step <= csr.wr_data;
            end else begin
                step <= step_next;
            end
            if (csr.wr_en && csr.wr_addr == `EMU_TRIG_EN) begin
                trig_en <= csr.wr_data;
            end
            trig_stat <= trig;
        end
    end

    always_comb begin
        stat                      = '0;
        stat[`STAT_PAUSE_BIT]     = pause;
        stat[`STAT_DUT_RST_BIT]   = dut_rst;
        stat[`STAT_SCAN_BUSY_BIT] = scan_busy;
        stat[`STAT_STEP_TRIG_BIT] = step_trig;
    end

    always_comb begin
        case (csr.rd_addr)
            `EMU_STAT:      csr.run_rdata = stat;
            `EMU_CYCLE_LO:  csr.run_rdata = cycle[31:0];
            `EMU_CYCLE_HI:  csr.run_rdata = cycle[63:32];
            `EMU_STEP:      csr.run_rdata = step;
            `EMU_TRIG_STAT: csr.run_rdata = trig_stat;
            `EMU_TRIG_EN:   csr.run_rdata = trig_en;
            default:        csr.run_rdata = '0;
        endcase
    end

endmodule

//--- hdl/emu_scan_seq.sv
`include "emu_macros.svh"

module emu_scan_seq #(
    parameter int chain_ff_words  = `DEF_CHAIN_FF_WORDS,
    parameter int chain_mem_words = `DEF_CHAIN_MEM_WORDS
) (
    input  logic                clk,
    input  logic                rst,
    emu_csr_if.scan             csr,
    output logic                scan_busy,

    output logic                ff_shift,
    output emu_pkg::scan_word_t ff_di,
    input  emu_pkg::scan_word_t ff_do,
    output logic                ram_shift,
    output logic                ram_dir,
    output emu_pkg::scan_word_t ram_di,
    input  emu_pkg::scan_word_t ram_do,

    output logic                scan_out_valid,
    input  logic                scan_out_ready,
    output emu_pkg::scan_word_t scan_out_data,
    output logic                scan_out_last,
    input  logic                scan_in_valid,
    output logic                scan_in_ready,
    input  emu_pkg::scan_word_t scan_in_data
);

    localparam int max_words = (chain_ff_words > chain_mem_words) ?
                               chain_ff_words : chain_mem_words;
    localparam int cnt_w     = $clog2(max_words + 1);

    localparam logic [cnt_w-1:0] ff_last_idx  = cnt_w'(chain_ff_words - 1);
    localparam logic [cnt_w-1:0] ram_last_idx = cnt_w'(chain_mem_words - 1);

    emu_pkg::scan_state_e state;
    logic [cnt_w-1:0]     cnt;
    logic                 dir;
    logic                 xfer;
    logic                 ff_last;
    logic                 ram_last;
    logic                 start;

    assign scan_busy = (state != emu_pkg::IDLE);

    // One word per transfer, stalled by the stream side
    assign xfer     = scan_busy && (dir ? scan_in_valid : scan_out_ready);
    assign ff_last  = (cnt == ff_last_idx);
    assign ram_last = (cnt == ram_last_idx);

    assign start = csr.wr_en && (csr.wr_addr == `EMU_SCAN_CTRL) &&
                   csr.wr_data[`SCAN_START_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= emu_pkg::IDLE;
            cnt   <= '0;
            dir   <= 1'b0;
        end else begin
            case (state)
                emu_pkg::IDLE: begin
                    if (start) begin
                        dir   <= csr.wr_data[`SCAN_DIR_BIT];
                        cnt   <= '0;
                        state <= emu_pkg::FF;
                    end
                end
                emu_pkg::FF: begin
                    if (xfer) begin
                        if (ff_last) begin
                            cnt   <= '0;
                            state <= emu_pkg::RAM;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                emu_pkg::RAM: begin
                    if (xfer) begin
                        if (ram_last) begin
                            cnt   <= '0;
                            state <= emu_pkg::IDLE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= emu_pkg::IDLE;
                end
            endcase
        end
    end

    assign ff_shift  = (state == emu_pkg::FF) && xfer;
    assign ram_shift = (state == emu_pkg::RAM) && xfer;
    assign ram_dir   = dir;

    // Scan-out keeps the flip-flop contents by feeding them back in
    assign ff_di  = dir ? scan_in_data : ff_do;
    assign ram_di = scan_in_data;

    assign scan_out_valid = scan_busy && !dir;
    assign scan_out_data  = (state == emu_pkg::RAM) ? ram_do : ff_do;
    assign scan_out_last  = (state == emu_pkg::RAM) && ram_last;
    assign scan_in_ready  = scan_busy && dir;

    // Start bit position reads back as busy
    always_comb begin
        csr.scan_rdata = '0;
        if (csr.rd_addr == `EMU_SCAN_CTRL) begin
            csr.scan_rdata[`SCAN_START_BIT] = scan_busy;
            csr.scan_rdata[`SCAN_DIR_BIT]   = dir;
        end
    end

endmodule

//--- hdl/emu_ctrl_top.sv
`include "emu_macros.svh"

module emu_ctrl_top #(
    parameter int chain_ff_words  = `DEF_CHAIN_FF_WORDS,
    parameter int chain_mem_words = `DEF_CHAIN_MEM_WORDS
) (
    input  logic                clk,
    input  logic                rst,

    input  emu_pkg::csr_addr_t  awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  emu_pkg::csr_data_t  wdata,
    input  logic [3:0]          wstrb,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  emu_pkg::csr_addr_t  araddr,
    input  logic                arvalid,
    output logic                arready,
    output emu_pkg::csr_data_t  rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready,

    input  logic                stall,
    input  emu_pkg::trig_t      trig,
    output logic                target_fire,
    output logic                dut_clk_en,
    output logic                dut_rst,

    output logic                ff_shift,
    output emu_pkg::scan_word_t ff_di,
    input  emu_pkg::scan_word_t ff_do,
    output logic                ram_shift,
    output logic                ram_dir,
    output emu_pkg::scan_word_t ram_di,
    input  emu_pkg::scan_word_t ram_do,

    output logic                scan_out_valid,
    input  logic                scan_out_ready,
    output emu_pkg::scan_word_t scan_out_data,
    output logic                scan_out_last,
    input  logic                scan_in_valid,
    output logic                scan_in_ready,
    input  emu_pkg::scan_word_t scan_in_data
);

    logic scan_busy;

    emu_csr_if csr_if_i ();

    emu_csr_ctrl #(
        .chain_ff_words  (chain_ff_words),
        .chain_mem_words (chain_mem_words)
    ) emu_csr_ctrl_i (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .csr     (csr_if_i.ctrl)
    );

    emu_run_ctrl emu_run_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .csr         (csr_if_i.run),
        .stall       (stall),
        .trig        (trig),
        .scan_busy   (scan_busy),
        .target_fire (target_fire),
        .dut_clk_en  (dut_clk_en),
        .dut_rst     (dut_rst)
    );

    emu_scan_seq #(
        .chain_ff_words  (chain_ff_words),
        .chain_mem_words (chain_mem_words)
    ) emu_scan_seq_i (
        .clk            (clk),
        .rst            (rst),
        .csr            (csr_if_i.scan),
        .scan_busy      (scan_busy),
        .ff_shift       (ff_shift),
        .ff_di          (ff_di),
        .ff_do          (ff_do),
        .ram_shift      (ram_shift),
        .ram_dir        (ram_dir),
        .ram_di         (ram_di),
        .ram_do         (ram_do),
        .scan_out_valid (scan_out_valid),
        .scan_out_ready (scan_out_ready),
        .scan_out_data  (scan_out_data),
        .scan_out_last  (scan_out_last),
        .scan_in_valid  (scan_in_valid),
        .scan_in_ready  (scan_in_ready),
        .scan_in_data   (scan_in_data)
    );

endmodule

//--- verif/emu_ctrl_tb.sv
`include "emu_macros.svh"

module emu_ctrl_tb;

    localparam int ff_words    = `DEF_CHAIN_FF_WORDS;
    localparam int mem_words   = `DEF_CHAIN_MEM_WORDS;
    localparam int total_words = ff_words + mem_words;
    localparam int wait_limit  = 200;

    // Chain model output bases
    localparam emu_pkg::scan_word_t ff_base  = 64'h0F0F_0000_0000_1000;
    localparam emu_pkg::scan_word_t ram_base = 64'hA000_0000_0000_2000;

    // Start value chosen so the low word carries into the high word
    localparam emu_pkg::cycle_t cycle_start = 64'h0000_0012_FFFF_FFF0;
    localparam int              run_steps   = 20;
    localparam emu_pkg::cycle_t cycle_end   = cycle_start + emu_pkg::cycle_t'(run_steps);

    localparam emu_pkg::csr_data_t stat_pause = 32'd1 << `STAT_PAUSE_BIT;
    localparam emu_pkg::csr_data_t stat_rst   = 32'd1 << `STAT_DUT_RST_BIT;
    localparam emu_pkg::csr_data_t stat_step  = 32'd1 << `STAT_STEP_TRIG_BIT;
    localparam emu_pkg::csr_data_t scan_start = 32'd1 << `SCAN_START_BIT;
    localparam emu_pkg::csr_data_t scan_dir   = 32'd1 << `SCAN_DIR_BIT;

    typedef enum logic [2:0] {
        OP_WR,
        OP_RD,
        OP_TRIG,
        OP_HALT,
        OP_SCAN_OUT,
        OP_SCAN_IN
    } step_op_e;

    typedef struct packed {
        step_op_e           op;
        emu_pkg::csr_addr_t addr;
        emu_pkg::csr_data_t data;
        logic [3:0]         strb;
        emu_pkg::csr_data_t exp_data;
        logic [1:0]         exp_resp;
    } step_t;

    logic                clk;
    logic                rst;
    emu_pkg::csr_addr_t  awaddr;
    logic                awvalid;
    logic                awready;
    emu_pkg::csr_data_t  wdata;
    logic [3:0]          wstrb;
    logic                wvalid;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    emu_pkg::csr_addr_t  araddr;
    logic                arvalid;
    logic                arready;
    emu_pkg::csr_data_t  rdata;
    logic [1:0]          rresp;
    logic                rvalid;
    logic                rready;
    logic                stall;
    emu_pkg::trig_t      trig;
    logic                target_fire;
    logic                dut_clk_en;
    logic                dut_rst;
    logic                ff_shift;
    emu_pkg::scan_word_t ff_di;
    emu_pkg::scan_word_t ff_do;
    logic                ram_shift;
    logic                ram_dir;
    emu_pkg::scan_word_t ram_di;
    emu_pkg::scan_word_t ram_do;
    logic                scan_out_valid;
    logic                scan_out_ready;
    emu_pkg::scan_word_t scan_out_data;
    logic                scan_out_last;
    logic                scan_in_valid;
    logic                scan_in_ready;
    emu_pkg::scan_word_t scan_in_data;

    step_t               steps[$];
    emu_pkg::scan_word_t scan_in_words [total_words];

    // Chain model state
    int unsigned         ff_count = 0;
    int unsigned         ram_count = 0;
    emu_pkg::scan_word_t taken[$];

    emu_ctrl_top emu_ctrl_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Chains count their shifts and record what was shifted in
    assign ff_do  = ff_base + emu_pkg::scan_word_t'(ff_count);
    assign ram_do = ram_base + emu_pkg::scan_word_t'(ram_count);

    always @(posedge clk) begin
        if (ff_shift) begin
            taken.push_back(ff_di);
            ff_count <= ff_count + 1;
        end
        if (ram_shift) begin
            taken.push_back(ram_di);
            ram_count <= ram_count + 1;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_data(input string name, input emu_pkg::csr_data_t got,
                              input emu_pkg::csr_data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input emu_pkg::scan_word_t got,
                              input emu_pkg::scan_word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // One more cycle of a wait loop, bounded by its own counter
    task automatic wait_step(inout int n, input string what);
        n = n + 1;
        if (n > wait_limit) begin
            stop_run({"Timed out waiting for ", what});
        end
        @(negedge clk);
    endtask

    task automatic random_gap();
        repeat ($urandom_range(0, 2)) @(negedge clk);
    endtask

    task automatic send_aw(input emu_pkg::csr_addr_t addr);
        int n;
        n = 0;
        random_gap();
        awaddr  = addr;
        awvalid = 1'b1;
        while (!awready) wait_step(n, "awready");
        @(negedge clk);
        awvalid = 1'b0;
    endtask

    task automatic send_w(input emu_pkg::csr_data_t data, input logic [3:0] strb);
        int n;
        n = 0;
        random_gap();
        wdata  = data;
        wstrb  = strb;
        wvalid = 1'b1;
        while (!wready) wait_step(n, "wready");
        @(negedge clk);
        wvalid = 1'b0;
    endtask

    task automatic bus_write(input emu_pkg::csr_addr_t addr, input emu_pkg::csr_data_t data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        n = 0;
        fork
            send_aw(addr);
            send_w(data, strb);
        join
        random_gap();
        bready = 1'b1;
        while (!bvalid) wait_step(n, "bvalid");
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic bus_read(input emu_pkg::csr_addr_t addr, output emu_pkg::csr_data_t data,
                            output logic [1:0] resp);
        int n;
        int m;
        n = 0;
        m = 0;
        random_gap();
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) wait_step(n, "arready");
        @(negedge clk);
        arvalid = 1'b0;
        random_gap();
        rready = 1'b1;
        while (!rvalid) wait_step(m, "rvalid");
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // Chains are idle here, so every firing cycle is an enabled cycle
    task automatic wait_halt();
        int n;
        n = 0;
        while (target_fire) begin
            check_bit("dut_clk_en", dut_clk_en, 1'b1);
            wait_step(n, "target_fire to fall");
        end
    endtask

    // Words must come out in chain order, flip-flops first
    task automatic run_scan_out();
        int                  idx;
        int                  n;
        emu_pkg::scan_word_t exp;
        idx = 0;
        n   = 0;
        while (idx < total_words) begin
            scan_out_ready = ($urandom_range(0, 3) != 0);
            if (scan_out_valid && scan_out_ready) begin
                if (idx < ff_words) begin
                    exp = ff_base + emu_pkg::scan_word_t'(idx);
                end else begin
                    exp = ram_base + emu_pkg::scan_word_t'(idx - ff_words);
                end
                check_word($sformatf("scan_out_data[%0d]", idx), scan_out_data, exp);
                check_bit("scan_out_last", scan_out_last, idx == total_words - 1);
                check_bit("ram_dir", ram_dir, 1'b0);
                idx = idx + 1;
            end
            wait_step(n, "scan-out words");
        end
        scan_out_ready = 1'b0;
    endtask

    task automatic run_scan_in();
        int idx;
        int n;
        idx = 0;
        n   = 0;
        taken.delete();
        while (idx < total_words) begin
            scan_in_valid = ($urandom_range(0, 3) != 0);
            // Inverted word while not valid, so a stray sample shows up
            scan_in_data  = scan_in_valid ? scan_in_words[idx] : ~scan_in_words[idx];
            if (scan_in_valid && scan_in_ready) begin
                check_bit("ram_dir", ram_dir, 1'b1);
                idx = idx + 1;
            end
            wait_step(n, "scan-in transfers");
        end
        scan_in_valid = 1'b0;
        if (taken.size() != total_words) begin
            stop_run($sformatf("Chain model took %0d words instead of %0d",
                               taken.size(), total_words));
        end
        foreach (taken[i]) begin
            check_word($sformatf("chain word %0d", i), taken[i], scan_in_words[i]);
        end
    endtask

    task automatic add_write(input emu_pkg::csr_addr_t addr, input emu_pkg::csr_data_t data,
                             input logic [3:0] strb, input logic [1:0] resp);
        steps.push_back('{OP_WR, addr, data, strb, '0, resp});
    endtask

    task automatic add_read(input emu_pkg::csr_addr_t addr, input emu_pkg::csr_data_t exp);
        steps.push_back('{OP_RD, addr, '0, 4'h0, exp, 2'b00});
    endtask

    task automatic add_op(input step_op_e op, input emu_pkg::csr_data_t data);
        steps.push_back('{op, 12'h000, data, 4'h0, '0, 2'b00});
    endtask

    task automatic build_table();
        for (int i = 0; i < total_words; i++) begin
            scan_in_words[i] = {32'h5CA1_0000 + 32'(i), ~(32'h0000_1000 + 32'(i))};
        end
        // Reset state and checkpoint size
        add_read(`EMU_STAT, stat_pause | stat_rst);
        add_read(`EMU_CKPT_SIZE, 32'd56);
        // Partial strobe is rejected
        add_write(`EMU_TRIG_EN, 32'hA5A5_0F0F, 4'b0011, `RESP_SLVERR);
        add_read(`EMU_TRIG_EN, 32'h0);
        add_write(`EMU_TRIG_EN, 32'hA5A5_0F0F, 4'hF, 2'b00);
        add_read(`EMU_TRIG_EN, 32'hA5A5_0F0F);
        // Step run
        add_write(`EMU_CYCLE_LO, cycle_start[31:0], 4'hF, 2'b00);
        add_write(`EMU_CYCLE_HI, cycle_start[63:32], 4'hF, 2'b00);
        add_read(`EMU_CYCLE_LO, cycle_start[31:0]);
        add_write(`EMU_STEP, 32'(run_steps), 4'hF, 2'b00);
        add_write(`EMU_STAT, 32'h0, 4'hF, 2'b00);
        add_op(OP_HALT, '0);
        add_read(`EMU_STAT, stat_pause | stat_step);
        add_read(`EMU_CYCLE_LO, cycle_end[31:0]);
        add_read(`EMU_CYCLE_HI, cycle_end[63:32]);
        add_read(`EMU_STEP, 32'h0);
        // Triggers, bit 4 enabled and bit 7 not
        add_write(`EMU_TRIG_EN, 32'h0000_0010, 4'hF, 2'b00);
        add_write(`EMU_STAT, 32'h0, 4'hF, 2'b00);
        add_op(OP_TRIG, 32'h0000_0080);
        add_read(`EMU_STAT, stat_step);
        add_op(OP_TRIG, 32'h0000_0090);
        add_op(OP_HALT, '0);
        add_read(`EMU_STAT, stat_pause);
        add_read(`EMU_TRIG_STAT, 32'h0000_0090);
        add_op(OP_TRIG, 32'h0);
        // Scan-out then scan-in
        add_write(`EMU_SCAN_CTRL, scan_start, 4'hF, 2'b00);
        add_op(OP_SCAN_OUT, '0);
        add_read(`EMU_SCAN_CTRL, 32'h0);
        add_read(`EMU_STAT, stat_pause);
        add_write(`EMU_SCAN_CTRL, scan_start | scan_dir, 4'hF, 2'b00);
        add_op(OP_SCAN_IN, '0);
        add_read(`EMU_SCAN_CTRL, scan_dir);
    endtask

    initial begin
        logic [1:0]         resp;
        emu_pkg::csr_data_t data;
        rst            = 1'b1;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = 4'h0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        stall          = 1'b0;
        trig           = '0;
        scan_out_ready = 1'b0;
        scan_in_valid  = 1'b0;
        scan_in_data   = '0;
        void'($urandom(2431));
        build_table();

        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_bit("dut_rst", dut_rst, 1'b1);
        check_bit("target_fire", target_fire, 1'b0);
        check_bit("dut_clk_en", dut_clk_en, 1'b0);

        foreach (steps[i]) begin
            case (steps[i].op)
                OP_WR: begin
                    bus_write(steps[i].addr, steps[i].data, steps[i].strb, resp);
                    check_resp($sformatf("bresp (step %0d)", i), resp, steps[i].exp_resp);
                end
                OP_RD: begin
                    bus_read(steps[i].addr, data, resp);
                    check_data($sformatf("rdata (step %0d)", i), data, steps[i].exp_data);
                    check_resp($sformatf("rresp (step %0d)", i), resp, 2'b00);
                end
                OP_TRIG: begin
                    trig = steps[i].data;
                    @(negedge clk);
                end
                OP_HALT:     wait_halt();
                OP_SCAN_OUT: run_scan_out();
                OP_SCAN_IN:  run_scan_in();
                default:     stop_run("Unknown operation in the stimulus table");
            endcase
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- files.f
+incdir+hdl
hdl/emu_pkg.sv
hdl/emu_csr_if.sv
hdl/emu_csr_ctrl.sv
hdl/emu_run_ctrl.sv
hdl/emu_scan_seq.sv
hdl/emu_ctrl_top.sv
verif/emu_ctrl_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
LINTFLAGS = --lint-only -Wall
TOP       = emu_ctrl_tb
RTL_TOP   = emu_ctrl_top
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
